// File: source/core_pkg.sv
package core_pkg;

    // Datapath width
    localparam int XLEN          = 32;
    localparam int NUM_ARCH_REGS = 32;

    // Window sizes
    localparam int ROB_DEPTH     = 16;
    // One spare physical register per ROB slot
    localparam int NUM_PHYS_REGS = NUM_ARCH_REGS + ROB_DEPTH;
    // Also the sender's starting credit count
    localparam int IQ_DEPTH      = 8;
    localparam int RS_ENTRIES    = 4;

    // Index widths
    localparam int TAG_W         = $clog2(NUM_PHYS_REGS);
    localparam int ROB_ID_W      = $clog2(ROB_DEPTH);

    typedef logic [XLEN-1:0]     word_t;
    typedef logic [4:0]          arch_reg_t;
    typedef logic [TAG_W-1:0]    phys_tag_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;

endpackage

// File: source/isa_pkg.sv
package isa_pkg;

    // ALU opcodes, register forms first
    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        // Immediate forms
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI
    } alu_op_e;

    // Immediate replaces rs2 for these
    function automatic logic uses_imm(input alu_op_e op);
        return (op == OP_ADDI) || (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);
    endfunction

    // Shift amount from low 5 bits of operand b
    function automatic logic [4:0] shamt(input logic [31:0] operand);
        return operand[4:0];
    endfunction

endpackage

// File: source/core_ifs.sv
// Rename to reservation station
interface dispatch_if;
    import core_pkg::*;
    import isa_pkg::*;

    logic      valid;
    alu_op_e   op;
    word_t     imm;
    phys_tag_t dst;
    phys_tag_t src1;
    phys_tag_t src2;
    logic      src1_rdy;
    logic      src2_rdy;
    rob_id_t   rob_id;

    modport rename (output valid, op, imm, dst, src1, src2, src1_rdy, src2_rdy, rob_id);
    modport issue  (input  valid, op, imm, dst, src1, src2, src1_rdy, src2_rdy, rob_id);
endinterface

// Rename to ROB, ROB hands back its tail slot
interface rob_alloc_if;
    import core_pkg::*;

    logic      valid;
    arch_reg_t rd;
    phys_tag_t new_tag;
    phys_tag_t old_tag;
    rob_id_t   rob_id;
    logic      full;

    modport rename (output valid, rd, new_tag, old_tag, input  rob_id, full);
    modport rob    (input  valid, rd, new_tag, old_tag, output rob_id, full);
endinterface

// Single result bus, no back-pressure
interface cdb_if;
    import core_pkg::*;

    logic      valid;
    phys_tag_t tag;
    rob_id_t   rob_id;
    word_t     value;

    modport drive  (output valid, tag, rob_id, value);
    modport listen (input  valid, tag, rob_id, value);
endinterface

// File: source/inst_queue.sv
module inst_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  isa_pkg::alu_op_e    in_op,
    input  core_pkg::arch_reg_t in_rd,
    input  core_pkg::arch_reg_t in_rs1,
    input  core_pkg::arch_reg_t in_rs2,
    input  core_pkg::word_t     in_imm,
    input  logic                pop,
    output logic                head_valid,
    output isa_pkg::alu_op_e    head_op,
    output core_pkg::arch_reg_t head_rd,
    output core_pkg::arch_reg_t head_rs1,
    output core_pkg::arch_reg_t head_rs2,
    output core_pkg::word_t     head_imm,
    output logic                credit_return
);
    import core_pkg::*;
    import isa_pkg::*;

    // Extra msb tells full from empty
    logic [$clog2(IQ_DEPTH):0] rd_ptr;
    logic [$clog2(IQ_DEPTH):0] wr_ptr;
    logic [$clog2(IQ_DEPTH)-1:0] rd_idx;
    logic [$clog2(IQ_DEPTH)-1:0] wr_idx;

    alu_op_e   q_op  [IQ_DEPTH];
    arch_reg_t q_rd  [IQ_DEPTH];
    arch_reg_t q_rs1 [IQ_DEPTH];
    arch_reg_t q_rs2 [IQ_DEPTH];
    word_t     q_imm [IQ_DEPTH];

    assign rd_idx = rd_ptr[$clog2(IQ_DEPTH)-1:0];
    assign wr_idx = wr_ptr[$clog2(IQ_DEPTH)-1:0];

    assign head_valid = (rd_ptr != wr_ptr);
    assign head_op    = q_op[rd_idx];
    assign head_rd    = q_rd[rd_idx];
    assign head_rs1   = q_rs1[rd_idx];
    assign head_rs2   = q_rs2[rd_idx];
    assign head_imm   = q_imm[rd_idx];

    // Pointers and the credit pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr        <= '0;
            wr_ptr        <= '0;
            credit_return <= 1'b0;
        end else begin
            // Credit rule keeps the sender from overflowing us
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // One credit back per departed entry
            credit_return <= pop;
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (in_valid) begin
            q_op[wr_idx]  <= in_op;
            q_rd[wr_idx]  <= in_rd;
            q_rs1[wr_idx] <= in_rs1;
            q_rs2[wr_idx] <= in_rs2;
            q_imm[wr_idx] <= in_imm;
        end
    end

endmodule

// File: source/rename_unit.sv
module rename_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                head_valid,
    input  isa_pkg::alu_op_e    head_op,
    input  core_pkg::arch_reg_t head_rd,
    input  core_pkg::arch_reg_t head_rs1,
    input  core_pkg::arch_reg_t head_rs2,
    input  core_pkg::word_t     head_imm,
    input  logic                iq_full,
    input  logic                free_valid,
    input  core_pkg::phys_tag_t free_tag,
    input  logic                prf_ready1,
    input  logic                prf_ready2,
    output logic                pop,
    output core_pkg::phys_tag_t prf_ready_addr1,
    output core_pkg::phys_tag_t prf_ready_addr2,
    dispatch_if.rename          disp,
    rob_alloc_if.rename         alloc
);
    import core_pkg::*;
    import isa_pkg::*;

    // Speculative map, arch reg to phys tag
    phys_tag_t rat [NUM_ARCH_REGS];

    // Free tags ring; never empty while ROB has room
    phys_tag_t free_fifo [ROB_DEPTH];
    rob_id_t   fl_rd_ptr;
    rob_id_t   fl_wr_ptr;
    phys_tag_t new_tag;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;

    // Stall on either downstream full
    assign pop      = head_valid && !iq_full && !alloc.full;
    assign new_tag  = free_fifo[fl_rd_ptr];
    assign src1_tag = rat[head_rs1];
    assign src2_tag = rat[head_rs2];

    // Ready bits looked up in the PRF this cycle
    assign prf_ready_addr1 = src1_tag;
    assign prf_ready_addr2 = src2_tag;

    assign disp.valid    = pop;
    assign disp.op       = head_op;
    assign disp.imm      = head_imm;
    assign disp.dst      = new_tag;
    assign disp.src1     = src1_tag;
    assign disp.src2     = src2_tag;
    assign disp.src1_rdy = prf_ready1;
    // Immediate ops never wait on rs2
    assign disp.src2_rdy = uses_imm(head_op) || prf_ready2;
    assign disp.rob_id   = alloc.rob_id;

    assign alloc.valid   = pop;
    assign alloc.rd      = head_rd;
    assign alloc.new_tag = new_tag;
    // x0 keeps tag 0, so its new tag is the one freed at commit
    assign alloc.old_tag = (head_rd == '0) ? new_tag : rat[head_rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map, upper tags free
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                rat[i] <= phys_tag_t'(i);
            end
            for (int i = 0; i < ROB_DEPTH; i++) begin
                free_fifo[i] <= phys_tag_t'(NUM_ARCH_REGS + i);
            end
            fl_rd_ptr <= '0;
            fl_wr_ptr <= '0;
        end else begin
            if (pop) begin
                fl_rd_ptr <= fl_rd_ptr + 1'b1;
                if (head_rd != '0) begin
                    rat[head_rd] <= new_tag;
                end
            end
            // Writes land on slots already consumed
            if (free_valid) begin
                free_fifo[fl_wr_ptr] <= free_tag;
                fl_wr_ptr            <= fl_wr_ptr + 1'b1;
            end
        end
    end

endmodule

// File: source/phys_reg_file.sv
module phys_reg_file (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::phys_tag_t ready_addr1,
    input  core_pkg::phys_tag_t ready_addr2,
    input  core_pkg::phys_tag_t rd_addr1,
    input  core_pkg::phys_tag_t rd_addr2,
    input  logic                alloc_valid,
    input  core_pkg::phys_tag_t alloc_tag,
    output logic                ready1,
    output logic                ready2,
    output core_pkg::word_t     rd_data1,
    output core_pkg::word_t     rd_data2,
    cdb_if.listen               cdb
);
    import core_pkg::*;

    word_t regs  [NUM_PHYS_REGS];
    logic  ready [NUM_PHYS_REGS];

    // Rename-side ready lookup
    assign ready1 = ready[ready_addr1];
    assign ready2 = ready[ready_addr2];

    // Issue-side operand read, p0 hardwired to zero
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Mapped registers start ready at zero
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                regs[i]  <= '0;
                ready[i] <= 1'b1;
            end
        end else begin
            // A fresh destination waits for its result
            if (alloc_valid) begin
                ready[alloc_tag] <= 1'b0;
            end
            // Tags differ, an allocated tag is never in flight
            if (cdb.valid) begin
                regs[cdb.tag]  <= cdb.value;
                ready[cdb.tag] <= 1'b1;
            end
        end
    end

endmodule

// File: source/issue_queue.sv
module issue_queue (
    input  logic                clk,
    input  logic                rst,
    output logic                full,
    output logic                issue_valid,
    output isa_pkg::alu_op_e    issue_op,
    output core_pkg::word_t     issue_imm,
    output core_pkg::phys_tag_t issue_dst,
    output core_pkg::rob_id_t   issue_rob_id,
    output core_pkg::phys_tag_t rd_addr1,
    output core_pkg::phys_tag_t rd_addr2,
    dispatch_if.issue           disp,
    cdb_if.listen               cdb
);
    import core_pkg::*;
    import isa_pkg::*;

    typedef logic [$clog2(RS_ENTRIES)-1:0] slot_idx_t;

    logic      slot_valid [RS_ENTRIES];
    alu_op_e   slot_op    [RS_ENTRIES];
    word_t     slot_imm   [RS_ENTRIES];
    phys_tag_t slot_dst   [RS_ENTRIES];
    phys_tag_t slot_src1  [RS_ENTRIES];
    phys_tag_t slot_src2  [RS_ENTRIES];
    logic      slot_rdy1  [RS_ENTRIES];
    logic      slot_rdy2  [RS_ENTRIES];
    rob_id_t   slot_rob   [RS_ENTRIES];

    slot_idx_t wr_idx;
    slot_idx_t iss_idx;

    // Lowest free slot and lowest ready slot
    always_comb begin
        full        = 1'b1;
        wr_idx      = '0;
        issue_valid = 1'b0;
        iss_idx     = '0;
        // Walk down so the lowest index wins
        for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                full   = 1'b0;
                wr_idx = slot_idx_t'(i);
            end
            if (slot_valid[i] && slot_rdy1[i] && slot_rdy2[i]) begin
                issue_valid = 1'b1;
                iss_idx     = slot_idx_t'(i);
            end
        end
    end

    assign issue_op     = slot_op[iss_idx];
    assign issue_imm    = slot_imm[iss_idx];
    assign issue_dst    = slot_dst[iss_idx];
    assign issue_rob_id = slot_rob[iss_idx];
    // PRF read happens in the issue cycle
    assign rd_addr1     = slot_src1[iss_idx];
    assign rd_addr2     = slot_src2[iss_idx];

    // Occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RS_ENTRIES; i++) begin
                slot_valid[i] <= 1'b0;
            end
        end else begin
            if (issue_valid) begin
                slot_valid[iss_idx] <= 1'b0;
            end
            // Free slot is never the issuing one
            if (disp.valid) begin
                slot_valid[wr_idx] <= 1'b1;
            end
        end
    end

    // Slot contents and bus wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            if (cdb.valid && slot_src1[i] == cdb.tag) begin
                slot_rdy1[i] <= 1'b1;
            end
            if (cdb.valid && slot_src2[i] == cdb.tag) begin
                slot_rdy2[i] <= 1'b1;
            end
        end
        if (disp.valid) begin
            slot_op[wr_idx]   <= disp.op;
            slot_imm[wr_idx]  <= disp.imm;
            slot_dst[wr_idx]  <= disp.dst;
            slot_src1[wr_idx] <= disp.src1;
            slot_src2[wr_idx] <= disp.src2;
            slot_rob[wr_idx]  <= disp.rob_id;
            // Catch a broadcast the PRF has not yet recorded
            slot_rdy1[wr_idx] <= disp.src1_rdy || (cdb.valid && disp.src1 == cdb.tag);
            slot_rdy2[wr_idx] <= disp.src2_rdy || (cdb.valid && disp.src2 == cdb.tag);
        end
    end

endmodule

// File: source/alu_unit.sv
module alu_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    input  isa_pkg::alu_op_e    issue_op,
    input  core_pkg::word_t     issue_imm,
    input  core_pkg::phys_tag_t issue_dst,
    input  core_pkg::rob_id_t   issue_rob_id,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    cdb_if.drive                cdb
);
    import core_pkg::*;
    import isa_pkg::*;

    word_t      op_b;
    word_t      result;
    logic [4:0] sh;

    assign op_b = uses_imm(issue_op) ? issue_imm : rs2_data;
    assign sh   = shamt(op_b);

    always_comb begin
        case (issue_op)
            OP_ADD, OP_ADDI: result = rs1_data + op_b;
            OP_SUB:          result = rs1_data - op_b;
            OP_AND, OP_ANDI: result = rs1_data & op_b;
            OP_OR, OP_ORI:   result = rs1_data | op_b;
            OP_XOR, OP_XORI: result = rs1_data ^ op_b;
            OP_SLL:          result = rs1_data << sh;
            OP_SRL:          result = rs1_data >> sh;
            OP_SRA:          result = word_t'($signed(rs1_data) >>> sh);
            // Compares give 1 or 0
            OP_SLT:          result = word_t'($signed(rs1_data) < $signed(op_b));
            OP_SLTU:         result = word_t'(rs1_data < op_b);
            default:         result = '0;
        endcase
    end

    // Broadcast one cycle after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb.tag    <= issue_dst;
        cdb.rob_id <= issue_rob_id;
        cdb.value  <= result;
    end

endmodule

// File: source/reorder_buffer.sv
module reorder_buffer (
    input  logic                clk,
    input  logic                rst,
    output logic                commit_valid,
    output core_pkg::arch_reg_t commit_rd,
    output core_pkg::word_t     commit_value,
    output logic                free_valid,
    output core_pkg::phys_tag_t free_tag,
    rob_alloc_if.rob            alloc,
    cdb_if.listen               cdb
);
    import core_pkg::*;

    // Msb is the wrap bit
    logic [ROB_ID_W:0] head_ptr;
    logic [ROB_ID_W:0] tail_ptr;
    rob_id_t           head_idx;
    rob_id_t           tail_idx;
    logic              retire;

    arch_reg_t ent_rd    [ROB_DEPTH];
    phys_tag_t ent_old   [ROB_DEPTH];
    logic      ent_done  [ROB_DEPTH];
    word_t     ent_value [ROB_DEPTH];

    assign head_idx = head_ptr[ROB_ID_W-1:0];
    assign tail_idx = tail_ptr[ROB_ID_W-1:0];

    // Same slot, opposite wrap
    assign alloc.full   = (head_ptr[ROB_ID_W] != tail_ptr[ROB_ID_W]) && (head_idx == tail_idx);
    assign alloc.rob_id = tail_idx;

    // Head leaves once done and occupied
    assign retire     = (head_ptr != tail_ptr) && ent_done[head_idx];
    // Tag goes back at the same edge the slot frees
    assign free_valid = retire;
    assign free_tag   = ent_old[head_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr     <= '0;
            tail_ptr     <= '0;
            commit_valid <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_done[i] <= 1'b0;
            end
        end else begin
            if (alloc.valid) begin
                ent_done[tail_idx] <= 1'b0;
                tail_ptr           <= tail_ptr + 1'b1;
            end
            // Never the tail slot, that one is empty
            if (cdb.valid) begin
                ent_done[cdb.rob_id] <= 1'b1;
            end
            if (retire) begin
                head_ptr <= head_ptr + 1'b1;
            end
            commit_valid <= retire;
        end
    end

    // Entry payload and registered commit port
    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            ent_rd[tail_idx]  <= alloc.rd;
            ent_old[tail_idx] <= alloc.old_tag;
        end
        if (cdb.valid) begin
            ent_value[cdb.rob_id] <= cdb.value;
        end
        commit_rd    <= ent_rd[head_idx];
        commit_value <= ent_value[head_idx];
    end

endmodule

// File: source/ooo_core.sv
module ooo_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  isa_pkg::alu_op_e    in_op,
    input  core_pkg::arch_reg_t in_rd,
    input  core_pkg::arch_reg_t in_rs1,
    input  core_pkg::arch_reg_t in_rs2,
    input  core_pkg::word_t     in_imm,
    output logic                credit_return,
    output logic                commit_valid,
    output core_pkg::arch_reg_t commit_rd,
    output core_pkg::word_t     commit_value
);
    import core_pkg::*;
    import isa_pkg::*;

    dispatch_if  disp ();
    rob_alloc_if alloc ();
    cdb_if       cdb ();

    // Queue head into rename
    logic      head_valid;
    alu_op_e   head_op;
    arch_reg_t head_rd;
    arch_reg_t head_rs1;
    arch_reg_t head_rs2;
    word_t     head_imm;
    logic      iq_pop;

    // Rename side
    logic      iq_full;
    logic      free_valid;
    phys_tag_t free_tag;
    logic      prf_ready1;
    logic      prf_ready2;
    phys_tag_t prf_ready_addr1;
    phys_tag_t prf_ready_addr2;

    // Issue to execute
    logic      issue_valid;
    alu_op_e   issue_op;
    word_t     issue_imm;
    phys_tag_t issue_dst;
    rob_id_t   issue_rob_id;
    phys_tag_t rd_addr1;
    phys_tag_t rd_addr2;
    word_t     rd_data1;
    word_t     rd_data2;

    inst_queue u_inst_queue (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_rd         (in_rd),
        .in_rs1        (in_rs1),
        .in_rs2        (in_rs2),
        .in_imm        (in_imm),
        .pop           (iq_pop),
        .head_valid    (head_valid),
        .head_op       (head_op),
        .head_rd       (head_rd),
        .head_rs1      (head_rs1),
        .head_rs2      (head_rs2),
        .head_imm      (head_imm),
        .credit_return (credit_return)
    );

    rename_unit u_rename_unit (
        .clk             (clk),
        .rst             (rst),
        .head_valid      (head_valid),
        .head_op         (head_op),
        .head_rd         (head_rd),
        .head_rs1        (head_rs1),
        .head_rs2        (head_rs2),
        .head_imm        (head_imm),
        .iq_full         (iq_full),
        .free_valid      (free_valid),
        .free_tag        (free_tag),
        .prf_ready1      (prf_ready1),
        .prf_ready2      (prf_ready2),
        .pop             (iq_pop),
        .prf_ready_addr1 (prf_ready_addr1),
        .prf_ready_addr2 (prf_ready_addr2),
        .disp            (disp.rename),
        .alloc           (alloc.rename)
    );

    // Allocation clears the ready bit of the new tag
    phys_reg_file u_phys_reg_file (
        .clk         (clk),
        .rst         (rst),
        .ready_addr1 (prf_ready_addr1),
        .ready_addr2 (prf_ready_addr2),
        .rd_addr1    (rd_addr1),
        .rd_addr2    (rd_addr2),
        .alloc_valid (alloc.valid),
        .alloc_tag   (alloc.new_tag),
        .ready1      (prf_ready1),
        .ready2      (prf_ready2),
        .rd_data1    (rd_data1),
        .rd_data2    (rd_data2),
        .cdb         (cdb.listen)
    );

    issue_queue u_issue_queue (
        .clk          (clk),
        .rst          (rst),
        .full         (iq_full),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_imm    (issue_imm),
        .issue_dst    (issue_dst),
        .issue_rob_id (issue_rob_id),
        .rd_addr1     (rd_addr1),
        .rd_addr2     (rd_addr2),
        .disp         (disp.issue),
        .cdb          (cdb.listen)
    );

    alu_unit u_alu_unit (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_imm    (issue_imm),
        .issue_dst    (issue_dst),
        .issue_rob_id (issue_rob_id),
        .rs1_data     (rd_data1),
        .rs2_data     (rd_data2),
        .cdb          (cdb.drive)
    );

    reorder_buffer u_reorder_buffer (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .free_valid   (free_valid),
        .free_tag     (free_tag),
        .alloc        (alloc.rob),
        .cdb          (cdb.listen)
    );

endmodule

// File: verification/ooo_core_properties.sv
module ooo_core_properties (
    input logic                clk,
    input logic                rst,
    input logic                commit_valid,
    input logic                credit_return,
    input core_pkg::arch_reg_t commit_rd
);
    timeunit 1ns;
    timeprecision 1ps;

    // Registered outputs settle one edge into reset
    commit_low_in_reset: assert property (
        @(posedge clk) rst && $past(rst) |-> !commit_valid
    ) else $error("commit_valid went high while rst was held");

    credit_low_in_reset: assert property (
        @(posedge clk) rst && $past(rst) |-> !credit_return
    ) else $error("credit_return went high while rst was held");

    // A retiring entry always names a real register
    commit_rd_known: assert property (
        @(posedge clk) disable iff (rst) commit_valid |-> !$isunknown(commit_rd)
    ) else $error("commit_rd unknown during a commit");

endmodule

bind ooo_core ooo_core_properties u_properties (
    .clk           (clk),
    .rst           (rst),
    .commit_valid  (commit_valid),
    .credit_return (credit_return),
    .commit_rd     (commit_rd)
);

// File: verification/tb_ooo_core.sv
module tb_clock_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end
endmodule

module tb_ooo_core;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;
    import isa_pkg::*;

    localparam int CREDIT_LIMIT  = 500;
    localparam int DRAIN_LIMIT   = 2000;
    localparam int NUM_BURSTS    = 40;
    localparam int EXHAUST_LIMIT = 64;

    logic      clk;
    logic      rst;
    logic      in_valid;
    alu_op_e   in_op;
    arch_reg_t in_rd;
    arch_reg_t in_rs1;
    arch_reg_t in_rs2;
    word_t     in_imm;
    logic      credit_return;
    logic      commit_valid;
    arch_reg_t commit_rd;
    word_t     commit_value;

    // Architectural state of the reference model
    word_t     arch_regs [NUM_ARCH_REGS];
    // Expected commits in send order
    arch_reg_t exp_rd  [$];
    word_t     exp_val [$];
    arch_reg_t front_rd;
    word_t     front_val;

    integer seed;
    int     sent;
    int     commits;
    int     spent;
    int     returned;
    int     credit_stalls;
    int     value_errors;
    int     other_errors;
    int     burst_len;

    tb_clock_gen u_clk_gen (.clk(clk));

    ooo_core u_dut (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_rd         (in_rd),
        .in_rs1        (in_rs1),
        .in_rs2        (in_rs2),
        .in_imm        (in_imm),
        .credit_return (credit_return),
        .commit_valid  (commit_valid),
        .commit_rd     (commit_rd),
        .commit_value  (commit_value)
    );

    // Sender's view of free queue slots
    function automatic int credits_left();
        return IQ_DEPTH - spent + returned;
    endfunction

    function automatic logic op_has_imm(input alu_op_e op);
        case (op)
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI: return 1'b1;
            default:                           return 1'b0;
        endcase
    endfunction

    // Expected ALU result per opcode
    // Shifts use the low 5 bits of b
    function automatic word_t ref_result(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            OP_ADD, OP_ADDI: return a + b;
            OP_SUB:          return a - b;
            OP_AND, OP_ANDI: return a & b;
            OP_OR, OP_ORI:   return a | b;
            OP_XOR, OP_XORI: return a ^ b;
            OP_SLL:          return a << b[4:0];
            OP_SRL:          return a >> b[4:0];
            OP_SRA:          return word_t'($signed(a) >>> b[4:0]);
            OP_SLT:          return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU:         return (a < b) ? 32'd1 : 32'd0;
            default:         return '0;
        endcase
    endfunction

    // Wait for a credit, then present one instruction for one edge
    task automatic send_instr(input alu_op_e op, input arch_reg_t rd, input arch_reg_t rs1,
                              input arch_reg_t rs2, input word_t imm);
        int    cycles;
        word_t b;
        word_t res;
        cycles = 0;
        @(posedge clk);
        while (credits_left() == 0 && cycles < CREDIT_LIMIT) begin
            in_valid <= 1'b0;
            credit_stalls++;
            @(posedge clk);
            cycles++;
        end
        if (credits_left() == 0) begin
            $display("Timed out waiting for an input credit");
            other_errors++;
            in_valid <= 1'b0;
        end else begin
            in_valid <= 1'b1;
            in_op    <= op;
            in_rd    <= rd;
            in_rs1   <= rs1;
            in_rs2   <= rs2;
            in_imm   <= imm;
            spent++;
            sent++;
            // Model executes in send order
            b   = op_has_imm(op) ? imm : arch_regs[rs2];
            res = ref_result(op, arch_regs[rs1], b);
            if (rd != '0) begin
                arch_regs[rd] = res;
            end
            exp_rd.push_back(rd);
            exp_val.push_back(res);
        end
    endtask

    // Small register pool keeps dependencies frequent
    task automatic send_random();
        logic [3:0] code;
        arch_reg_t  rd;
        arch_reg_t  rs1;
        arch_reg_t  rs2;
        word_t      imm;
        code = 4'($unsigned($random(seed)) % 14);
        rd   = arch_reg_t'($unsigned($random(seed)) % 6);
        rs1  = arch_reg_t'($unsigned($random(seed)) % 6);
        rs2  = arch_reg_t'($unsigned($random(seed)) % 6);
        imm  = $random(seed);
        send_instr(alu_op_e'(code), rd, rs1, rs2, imm);
    endtask

    // Serial chain through x1 issues only every other cycle
    // Queue backs up until the sender has no credit left
    task automatic run_out_of_credits();
        int count;
        int stalls_before;
        count         = 0;
        stalls_before = credit_stalls;
        while (credit_stalls == stalls_before && count < EXHAUST_LIMIT) begin
            send_instr(alu_op_e'(4'($unsigned($random(seed)) % 14)), 5'd1, 5'd1, 5'd1,
                       $random(seed));
            count++;
        end
        assert (credit_stalls != stalls_before)
        else begin
            $display("Sender never ran out of credits during the serial chain");
            other_errors++;
        end
    endtask

    task automatic go_idle(input int cycles);
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    // All results committed and every credit home
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_rd.size() != 0 || credits_left() != IQ_DEPTH) && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_rd.size() != 0 || credits_left() != IQ_DEPTH) begin
            $display("Timed out waiting for drain, %0d commits due, %0d credits held",
                     exp_rd.size(), credits_left());
            other_errors++;
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!commit_valid && !credit_return)
            else begin
                $display("Commit or credit activity before any instruction was sent");
                other_errors++;
            end
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (credit_return) begin
                returned++;
            end
            assert (credits_left() <= IQ_DEPTH)
            else begin
                $display("Credit count rose above the queue depth to %0d", credits_left());
                other_errors++;
            end
            if (commit_valid) begin
                commits++;
                if (exp_rd.size() == 0) begin
                    $display("Commit seen with no instruction outstanding");
                    other_errors++;
                end else begin
                    front_rd  = exp_rd.pop_front();
                    front_val = exp_val.pop_front();
                    assert (commit_rd == front_rd)
                    else begin
                        $display("ERROR: commit_rd got 0x%h expected 0x%h", commit_rd, front_rd);
                        value_errors++;
                    end
                    assert (commit_value == front_val)
                    else begin
                        $display("ERROR: commit_value got 0x%h expected 0x%h",
                                 commit_value, front_val);
                        value_errors++;
                    end
                end
            end
        end
    end

    initial begin
        seed          = 60448;
        sent          = 0;
        commits       = 0;
        spent         = 0;
        returned      = 0;
        credit_stalls = 0;
        value_errors  = 0;
        other_errors  = 0;
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            arch_regs[i] = '0;
        end
        rst      = 1'b1;
        in_valid = 1'b0;
        in_op    = OP_ADD;
        in_rd    = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        in_imm   = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        expect_quiet(10);

        // Seed x1 and x2, then chain every opcode through x3
        send_instr(OP_ADDI, 5'd1, 5'd0, 5'd0, $random(seed));
        send_instr(OP_ADDI, 5'd2, 5'd0, 5'd0, 32'h0000_0013);
        for (int i = 0; i < 14; i++) begin
            send_instr(alu_op_e'(4'(i)), 5'd3, 5'd3, (i % 2 == 0) ? 5'd1 : 5'd2,
                       $random(seed));
        end

        // Writes to x0 commit but leave x0 at zero
        send_instr(OP_ADDI, 5'd0, 5'd1, 5'd0, 32'h0000_1234);
        send_instr(OP_ADD, 5'd4, 5'd0, 5'd3, '0);
        send_instr(OP_SUB, 5'd5, 5'd0, 5'd4, '0);
        send_instr(OP_OR, 5'd0, 5'd5, 5'd4, '0);
        send_instr(OP_XORI, 5'd4, 5'd0, 5'd0, 32'hffff_0000);
        go_idle(2);
        wait_drain();

        // Random bursts with short idle gaps
        for (int n = 0; n < NUM_BURSTS; n++) begin
            burst_len = 1 + ($unsigned($random(seed)) % 20);
            for (int k = 0; k < burst_len; k++) begin
                send_random();
            end
            go_idle($unsigned($random(seed)) % 6);
        end

        // Back-to-back dependent burst until the credits are gone
        run_out_of_credits();
        go_idle(2);
        wait_drain();

        assert (commits == sent)
        else begin
            $display("Committed %0d instructions but sent %0d", commits, sent);
            other_errors++;
        end

        $display("Sent %0d, committed %0d, value errors %0d, other errors %0d",
                 sent, commits, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: flist.f
source/core_pkg.sv
source/isa_pkg.sv
source/core_ifs.sv
source/inst_queue.sv
source/rename_unit.sv
source/phys_reg_file.sv
source/issue_queue.sv
source/alu_unit.sv
source/reorder_buffer.sv
source/ooo_core.sv
verification/ooo_core_properties.sv
verification/tb_ooo_core.sv

// File: run.sh
#!/bin/sh
# Build the ooo_core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_core \
    -f flist.f -o tb_ooo_core_sim \
    && ./obj_dir/tb_ooo_core_sim | tee /dev/stderr | grep -q "All tests passed!" \
    && exit 0
echo "Simulation did not pass"
exit 1
